/* pipeline_input.txt */
# kind word rd value : inst lines, hex word, decimal rd, hex value
# bubble is an idle cycle, illegal holds only the word, end stops the stream
# immediate group
inst 00500093 1 00000005
inst fff00113 2 ffffffff
inst 00012193 3 00000001
inst fff13213 4 00000000
inst 00103293 5 00000001
inst 8000a313 6 00000000
inst 01f09393 7 80000000
inst 41f3d413 8 ffffffff
inst 0003d493 9 80000000
inst fff0c513 10 fffffffa
inst 0f00e593 11 000000f5
inst 7ff17613 12 000007ff
# register group
inst 401386b3 13 7ffffffb
inst 4053d733 14 c0000000
inst 001107b3 15 00000004
inst 0013a833 16 00000001
inst 0013b8b3 17 00000000
inst 00c09933 18 80000000
inst 001559b3 19 07ffffff
inst 00254a33 20 00000005
inst 0075eab3 21 800000f5
inst 00b57b33 22 000000f0
# dependent chain with one and two bubbles
inst 06400b93 23 00000064
inst 001b8b93 23 00000065
inst 017b8c33 24 000000ca
bubble
inst 417c0cb3 25 00000065
bubble
bubble
inst f9bc8d13 26 00000000
# x0 write and read back
inst 00708013 0 0000000c
inst 00100db3 27 00000005
# AND with the alternate funct7 halts the pipeline
illegal 40007033
inst 00100093 1 00000001
end

/* files.f */
core_pkg.sv
isa_pkg.sv
regfile.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
pipeline.sv
tb_pipeline.sv

/* Bender.yml */
package:
  name: pipeline

sources:
  - core_pkg.sv
  - isa_pkg.sv
  - regfile.sv
  - decode_stage.sv
  - execute_stage.sv
  - result_stage.sv
  - pipeline.sv
  - target: simulation
    files:
      - tb_pipeline.sv

/* tb_pipeline.sv */
/*
 * Testbench for the three-stage ALU pipeline
 * Streams instructions and bubbles from a data file and checks every
 * commit in order, then the retired count and the error halt
 */
`default_nettype none

module tb_pipeline
    import core_pkg::*;
    import isa_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES   = 10;
    localparam int COMMIT_LATENCY = 3;
    localparam int TIMEOUT_SLACK  = 20;
    localparam     INPUT_FILE     = "pipeline_input.txt";

    logic                 clock;
    logic                 reset;
    logic                 inst_valid;
    logic [31:0]          inst;
    logic                 commit_valid;
    logic                 commit_wr_en;
    logic [REG_IDX_W-1:0] commit_wr_idx;
    logic [XLEN-1:0]      commit_wr_data;
    logic [XLEN-1:0]      commit_npc;
    logic [XLEN-1:0]      retired_count;
    logic [ERR_W-1:0]     error_status;

    // Expected commits in arrival order
    logic [REG_IDX_W-1:0] exp_rd_q[$];
    logic [XLEN-1:0]      exp_data_q[$];
    logic [XLEN-1:0]      exp_npc_q[$];
    int                   exp_tag_q[$];

    int                   cycle_count;
    int                   cycle_limit;
    int                   line_count;
    int                   commits_seen;
    int                   accepted_count;
    int                   expected_retired;
    bit                   illegal_seen;
    int                   fd;

    pipeline dut_i (
        .clock          (clock),
        .reset          (reset),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .commit_valid   (commit_valid),
        .commit_wr_en   (commit_wr_en),
        .commit_wr_idx  (commit_wr_idx),
        .commit_wr_data (commit_wr_data),
        .commit_npc     (commit_npc),
        .retired_count  (retired_count),
        .error_status   (error_status)
    );

    // 8 ns period
    always #4 clock = ~clock;

    ////////////////////////////////////////////////////////////////////////////
    // Error reporting
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        $display("[ERROR] %s: expected 0x%h, actual 0x%h", name, expected, actual);
        stop_run();
    endtask

    task automatic report_event(input string what);
        $display("[ERROR] %s", what);
        stop_run();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // Quiet outputs straight after reset
    task automatic check_idle();
        assert (commit_valid == 1'b0)
            else report_value("idle commit_valid", 32'd0, commit_valid);
        assert (commit_wr_en == 1'b0)
            else report_value("idle commit_wr_en", 32'd0, commit_wr_en);
        assert (error_status == ERR_NONE)
            else report_value("idle error_status", ERR_NONE, error_status);
        assert (retired_count == '0)
            else report_value("idle retired_count", 32'd0, retired_count);
    endtask

    // One commit against the front of the queue
    task automatic check_commit();
        logic [REG_IDX_W-1:0] exp_rd;
        logic [XLEN-1:0]      exp_data;
        logic [XLEN-1:0]      exp_npc;
        int                   tag;
        assert (exp_data_q.size() != 0)
            else report_event("a commit appeared with no instruction outstanding");
        exp_rd   = exp_rd_q.pop_front();
        exp_data = exp_data_q.pop_front();
        exp_npc  = exp_npc_q.pop_front();
        tag      = exp_tag_q.pop_front();
        assert (commit_wr_idx == exp_rd)
            else report_value($sformatf("inst %0d rd", tag), exp_rd, commit_wr_idx);
        assert (commit_wr_data == exp_data)
            else report_value($sformatf("inst %0d data", tag), exp_data, commit_wr_data);
        assert (commit_npc == exp_npc)
            else report_value($sformatf("inst %0d npc", tag), exp_npc, commit_npc);
        // x0 commits but never writes
        assert (commit_wr_en == (exp_rd != '0))
            else report_value($sformatf("inst %0d wr_en", tag), exp_rd != '0,
                              commit_wr_en);
        // Counter lags the commit by one edge
        assert (retired_count == commits_seen)
            else report_value($sformatf("inst %0d retired", tag), commits_seen,
                              retired_count);
        assert (error_status == ERR_NONE)
            else report_value($sformatf("inst %0d status", tag), ERR_NONE,
                              error_status);
        commits_seen++;
    endtask

    task automatic check_final();
        logic [ERR_W-1:0] exp_status;
        exp_status = illegal_seen ? ERR_ILLEGAL : ERR_NONE;
        assert (retired_count == expected_retired)
            else report_value("final retired_count", expected_retired, retired_count);
        assert (error_status == exp_status)
            else report_value("final error_status", exp_status, error_status);
    endtask

    // Outputs are settled by the falling edge
    always @(negedge clock) begin
        if (!reset && commit_valid) begin
            check_commit();
        end
    end

    // Cycle budget
    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            report_event($sformatf("timeout, no finish after %0d cycles", cycle_count));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic count_lines(output int lines);
        logic [8*256-1:0] text;
        int               cfd;
        lines = 0;
        cfd   = $fopen(INPUT_FILE, "r");
        if (cfd == 0) begin
            report_event("could not open the instruction data file");
        end else begin
            while ($fgets(text, cfd) != 0) begin
                lines++;
            end
            $fclose(cfd);
        end
    endtask

    // Present one word for a single cycle
    task automatic drive_instruction(input logic [31:0] word);
        inst_valid = 1'b1;
        inst       = word;
        accepted_count++;
        @(negedge clock);
    endtask

    task automatic play_stream();
        logic [8*16-1:0]  kind;
        logic [8*256-1:0] rest;
        logic [31:0]      word;
        logic [31:0]      value;
        int               rd;
        int               code;
        bit               done;
        done = 1'b0;
        while (!done) begin
            kind = '0;
            code = $fscanf(fd, "%s", kind);
            if (code != 1) begin
                report_event("data file ended before its end record");
            end else if (kind == "#") begin
                code = $fgets(rest, fd);
            end else if (kind == "inst") begin
                code = $fscanf(fd, "%h %d %h", word, rd, value);
                if (code != 3) begin
                    report_event("malformed instruction line in the data file");
                end
                // Nothing behind an illegal word may commit
                if (!illegal_seen) begin
                    exp_rd_q.push_back(rd[REG_IDX_W-1:0]);
                    exp_data_q.push_back(value);
                    exp_npc_q.push_back(accepted_count * 4 + 4);
                    exp_tag_q.push_back(accepted_count);
                    expected_retired++;
                end
                drive_instruction(word);
            end else if (kind == "illegal") begin
                code = $fscanf(fd, "%h", word);
                illegal_seen = 1'b1;
                drive_instruction(word);
            end else if (kind == "bubble") begin
                inst_valid = 1'b0;
                @(negedge clock);
            end else if (kind == "end") begin
                inst_valid = 1'b0;
                done       = 1'b1;
            end else begin
                report_event("unknown record kind in the data file");
            end
        end
    endtask

    initial begin
        clock            = 1'b0;
        reset            = 1'b1;
        inst_valid       = 1'b0;
        inst             = '0;
        cycle_count      = 0;
        commits_seen     = 0;
        accepted_count   = 0;
        expected_retired = 0;
        illegal_seen     = 1'b0;

        // Budget from the stream length
        count_lines(line_count);
        cycle_limit = line_count + RESET_CYCLES + TIMEOUT_SLACK;
        fd = $fopen(INPUT_FILE, "r");

        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        check_idle();

        play_stream();
        $fclose(fd);

        // Drain the queue and leave room for any stray commit
        while (exp_data_q.size() != 0) begin
            @(negedge clock);
        end
        repeat (COMMIT_LATENCY + 1) @(negedge clock);
        check_final();

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

/* pipeline.sv */
/*
 * Pipeline top
 * Three-stage in-order ALU pipeline: decode with register read,
 * execute, and result with commit and write-back
 */
`default_nettype none

module pipeline
    import core_pkg::*;
    import isa_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 inst_valid,
    input  logic [31:0]          inst,
    output logic                 commit_valid,
    output logic                 commit_wr_en,
    output logic [REG_IDX_W-1:0] commit_wr_idx,
    output logic [XLEN-1:0]      commit_wr_data,
    output logic [XLEN-1:0]      commit_npc,
    output logic [XLEN-1:0]      retired_count,
    output logic [ERR_W-1:0]     error_status
);

    ////////////////////////////////////////////////////////////////////////////
    // Stage wires
    ////////////////////////////////////////////////////////////////////////////

    // Register file read
    logic [REG_IDX_W-1:0] rs1_idx;
    logic [REG_IDX_W-1:0] rs2_idx;
    logic [XLEN-1:0]      rs1_data;
    logic [XLEN-1:0]      rs2_data;

    // Decode to execute
    logic                 dec_valid;
    logic [ALU_OP_W-1:0]  dec_alu_op;
    logic [XLEN-1:0]      dec_operand_a;
    logic [XLEN-1:0]      dec_operand_b;
    logic [REG_IDX_W-1:0] dec_rd;
    logic [XLEN-1:0]      dec_pc;
    logic                 dec_illegal;

    // Execute to result, also the forwarding path
    logic                 ex_valid;
    logic [REG_IDX_W-1:0] ex_rd;
    logic [XLEN-1:0]      ex_result;
    logic [XLEN-1:0]      ex_pc;
    logic                 ex_illegal;

    // Write-back
    logic                 wr_en;
    logic [REG_IDX_W-1:0] wr_idx;
    logic [XLEN-1:0]      wr_data;

    ////////////////////////////////////////////////////////////////////////////
    // Stages
    ////////////////////////////////////////////////////////////////////////////

    regfile u_regfile (
        .clock    (clock),
        .reset    (reset),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_idx   (wr_idx),
        .wr_data  (wr_data)
    );

    decode_stage u_decode (
        .clock         (clock),
        .reset         (reset),
        .inst_valid    (inst_valid),
        .inst          (inst),
        .rs1_idx       (rs1_idx),
        .rs2_idx       (rs2_idx),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .ex_valid      (ex_valid),
        .ex_rd         (ex_rd),
        .ex_result     (ex_result),
        .dec_valid     (dec_valid),
        .dec_alu_op    (dec_alu_op),
        .dec_operand_a (dec_operand_a),
        .dec_operand_b (dec_operand_b),
        .dec_rd        (dec_rd),
        .dec_pc        (dec_pc),
        .dec_illegal   (dec_illegal)
    );

    execute_stage u_execute (
        .clock         (clock),
        .reset         (reset),
        .dec_valid     (dec_valid),
        .dec_alu_op    (dec_alu_op),
        .dec_operand_a (dec_operand_a),
        .dec_operand_b (dec_operand_b),
        .dec_rd        (dec_rd),
        .dec_pc        (dec_pc),
        .dec_illegal   (dec_illegal),
        .ex_valid      (ex_valid),
        .ex_rd         (ex_rd),
        .ex_result     (ex_result),
        .ex_pc         (ex_pc),
        .ex_illegal    (ex_illegal)
    );

    result_stage u_result (
        .clock          (clock),
        .reset          (reset),
        .ex_valid       (ex_valid),
        .ex_rd          (ex_rd),
        .ex_result      (ex_result),
        .ex_pc          (ex_pc),
        .ex_illegal     (ex_illegal),
        .wr_en          (wr_en),
        .wr_idx         (wr_idx),
        .wr_data        (wr_data),
        .commit_valid   (commit_valid),
        .commit_wr_en   (commit_wr_en),
        .commit_wr_idx  (commit_wr_idx),
        .commit_wr_data (commit_wr_data),
        .commit_npc     (commit_npc),
        .retired_count  (retired_count),
        .error_status   (error_status)
    );

endmodule

`default_nettype wire

/* result_stage.sv */
/*
 * Result stage
 * Commit register, register write-back, retired count and the
 * sticky error halt
 */
`default_nettype none

module result_stage
    import core_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 ex_valid,
    input  logic [REG_IDX_W-1:0] ex_rd,
    input  logic [XLEN-1:0]      ex_result,
    input  logic [XLEN-1:0]      ex_pc,
    input  logic                 ex_illegal,
    output logic                 wr_en,
    output logic [REG_IDX_W-1:0] wr_idx,
    output logic [XLEN-1:0]      wr_data,
    output logic                 commit_valid,
    output logic                 commit_wr_en,
    output logic [REG_IDX_W-1:0] commit_wr_idx,
    output logic [XLEN-1:0]      commit_wr_data,
    output logic [XLEN-1:0]      commit_npc,
    output logic [XLEN-1:0]      retired_count,
    output logic [ERR_W-1:0]     error_status
);

    logic                 res_valid;
    logic [REG_IDX_W-1:0] res_rd;
    logic [XLEN-1:0]      res_data;
    logic [XLEN-1:0]      res_pc;
    logic                 halted;

    always_ff @(posedge clock) begin
        if (reset) begin
            res_valid     <= 1'b0;
            retired_count <= '0;
            error_status  <= ERR_NONE;
        end else begin
            res_valid <= ex_valid;
            // Set on the same edge the bad instruction is captured
            if (ex_valid && ex_illegal) begin
                error_status <= ERR_ILLEGAL;
            end
            if (commit_valid) begin
                retired_count <= retired_count + XLEN'(1);
            end
        end
    end

    // Commit payload
    always_ff @(posedge clock) begin
        if (ex_valid) begin
            res_rd   <= ex_rd;
            res_data <= ex_result;
            res_pc   <= ex_pc;
        end
    end

    assign halted = (error_status != ERR_NONE);

    // Nothing commits once halted, the illegal one included
    assign commit_valid   = res_valid && !halted;
    assign commit_wr_en   = commit_valid && (res_rd != '0);
    assign commit_wr_idx  = res_rd;
    assign commit_wr_data = res_data;
    assign commit_npc     = res_pc + XLEN'(4);

    // Write-back mirrors the commit port
    assign wr_en   = commit_wr_en;
    assign wr_idx  = res_rd;
    assign wr_data = res_data;

endmodule

`default_nettype wire

/* execute_stage.sv */
/*
 * Execute stage
 * Pipeline register for the decoded operation and a single-cycle ALU
 */
`default_nettype none

module execute_stage
    import core_pkg::*;
    import isa_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 dec_valid,
    input  logic [ALU_OP_W-1:0]  dec_alu_op,
    input  logic [XLEN-1:0]      dec_operand_a,
    input  logic [XLEN-1:0]      dec_operand_b,
    input  logic [REG_IDX_W-1:0] dec_rd,
    input  logic [XLEN-1:0]      dec_pc,
    input  logic                 dec_illegal,
    output logic                 ex_valid,
    output logic [REG_IDX_W-1:0] ex_rd,
    output logic [XLEN-1:0]      ex_result,
    output logic [XLEN-1:0]      ex_pc,
    output logic                 ex_illegal
);

    logic [ALU_OP_W-1:0] alu_op;
    logic [XLEN-1:0]     op_a;
    logic [XLEN-1:0]     op_b;
    logic [4:0]          shamt;

    // Control
    always_ff @(posedge clock) begin
        if (reset) begin
            ex_valid   <= 1'b0;
            ex_illegal <= 1'b0;
        end else begin
            ex_valid   <= dec_valid;
            ex_illegal <= dec_illegal;
        end
    end

    // Operands and destination
    always_ff @(posedge clock) begin
        if (dec_valid) begin
            alu_op <= dec_alu_op;
            op_a   <= dec_operand_a;
            op_b   <= dec_operand_b;
            ex_rd  <= dec_rd;
            ex_pc  <= dec_pc;
        end
    end

    // Shift amount from the low bits of b
    assign shamt = op_b[4:0];

    // ALU
    always_comb begin
        case (alu_op)
            ALU_ADD:  ex_result = op_a + op_b;
            ALU_SUB:  ex_result = op_a - op_b;
            ALU_SLL:  ex_result = op_a << shamt;
            ALU_SLT:  ex_result = XLEN'($signed(op_a) < $signed(op_b));
            ALU_SLTU: ex_result = XLEN'(op_a < op_b);
            ALU_XOR:  ex_result = op_a ^ op_b;
            ALU_SRL:  ex_result = op_a >> shamt;
            // Arithmetic shift keeps the sign
            ALU_SRA:  ex_result = $signed(op_a) >>> shamt;
            ALU_OR:   ex_result = op_a | op_b;
            ALU_AND:  ex_result = op_a & op_b;
            default:  ex_result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* decode_stage.sv */
/*
 * Decode stage
 * Accepts the instruction stream, assigns program counters, decodes
 * the R-type and I-type ALU groups, reads operands with forwarding
 * from execute and flags illegal encodings
 */
`default_nettype none

module decode_stage
    import core_pkg::*;
    import isa_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 inst_valid,
    input  inst_word_t           inst,
    output logic [REG_IDX_W-1:0] rs1_idx,
    output logic [REG_IDX_W-1:0] rs2_idx,
    input  logic [XLEN-1:0]      rs1_data,
    input  logic [XLEN-1:0]      rs2_data,
    input  logic                 ex_valid,
    input  logic [REG_IDX_W-1:0] ex_rd,
    input  logic [XLEN-1:0]      ex_result,
    output logic                 dec_valid,
    output logic [ALU_OP_W-1:0]  dec_alu_op,
    output logic [XLEN-1:0]      dec_operand_a,
    output logic [XLEN-1:0]      dec_operand_b,
    output logic [REG_IDX_W-1:0] dec_rd,
    output logic [XLEN-1:0]      dec_pc,
    output logic                 dec_illegal
);

    inst_word_t      inst_q;
    logic [XLEN-1:0] pc_count;
    logic [XLEN-1:0] imm_ext;
    logic [XLEN-1:0] rs2_value;
    logic            is_op;
    logic            is_imm;
    logic            f7_base;
    logic            f7_alt;
    logic            f7_checked;
    logic            alt_allowed;
    logic            fwd_rs1;
    logic            fwd_rs2;

    ////////////////////////////////////////////////////////////////////////////
    // Input register and pc counter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            dec_valid <= 1'b0;
            pc_count  <= '0;
        end else begin
            dec_valid <= inst_valid;
            // One word per accepted instruction
            if (inst_valid) begin
                pc_count <= pc_count + XLEN'(4);
            end
        end
    end

    // Payload, only loaded on an accepted instruction
    always_ff @(posedge clock) begin
        if (inst_valid) begin
            inst_q <= inst;
            dec_pc <= pc_count;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////////////////////

    assign is_op   = (inst_q.r.opcode == OPC_OP);
    assign is_imm  = (inst_q.i.opcode == OPC_OP_IMM);
    assign f7_base = (inst_q.r.funct7 == F7_BASE);
    assign f7_alt  = (inst_q.r.funct7 == F7_ALT);

    // funct7 matters for every R-type and for the immediate shifts
    assign f7_checked  = is_op || (inst_q.i.funct3 == F3_SLL) || (inst_q.i.funct3 == F3_SR);
    // Alternate form exists only for SUB and SRA / SRAI
    assign alt_allowed = (inst_q.r.funct3 == F3_SR) || (is_op && inst_q.r.funct3 == F3_ADD);

    assign dec_illegal = !(is_op || is_imm) ||
                         (f7_checked && !(f7_base || (f7_alt && alt_allowed)));

    // ALU operation from funct3, funct7 picks SUB and SRA
    always_comb begin
        dec_alu_op = ALU_ADD;
        case (inst_q.r.funct3)
            F3_ADD:  dec_alu_op = (is_op && f7_alt) ? ALU_SUB : ALU_ADD;
            F3_SLL:  dec_alu_op = ALU_SLL;
            F3_SLT:  dec_alu_op = ALU_SLT;
            F3_SLTU: dec_alu_op = ALU_SLTU;
            F3_XOR:  dec_alu_op = ALU_XOR;
            F3_SR:   dec_alu_op = f7_alt ? ALU_SRA : ALU_SRL;
            F3_OR:   dec_alu_op = ALU_OR;
            F3_AND:  dec_alu_op = ALU_AND;
            default: dec_alu_op = ALU_ADD;
        endcase
    end

    assign rs1_idx = inst_q.r.rs1;
    assign rs2_idx = inst_q.r.rs2;
    assign dec_rd  = inst_q.r.rd;

    // Sign-extended 12-bit immediate
    assign imm_ext = {{(XLEN-12){inst_q.i.imm[11]}}, inst_q.i.imm};

    ////////////////////////////////////////////////////////////////////////////
    // Operand select
    ////////////////////////////////////////////////////////////////////////////

    // Instruction one ahead sits in execute, x0 never forwarded
    assign fwd_rs1 = ex_valid && (ex_rd == rs1_idx) && (rs1_idx != '0);
    assign fwd_rs2 = ex_valid && (ex_rd == rs2_idx) && (rs2_idx != '0);

    assign dec_operand_a = fwd_rs1 ? ex_result : rs1_data;
    assign rs2_value     = fwd_rs2 ? ex_result : rs2_data;

    // Immediate replaces rs2 for the I-type group
    assign dec_operand_b = is_imm ? imm_ext : rs2_value;

endmodule

`default_nettype wire

/* regfile.sv */
/*
 * Register file
 * Two read ports, one write port, write-through bypass, x0 reads zero
 */
`default_nettype none

module regfile
    import core_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic [REG_IDX_W-1:0] rs1_idx,
    input  logic [REG_IDX_W-1:0] rs2_idx,
    output logic [XLEN-1:0]      rs1_data,
    output logic [XLEN-1:0]      rs2_data,
    input  logic                 wr_en,
    input  logic [REG_IDX_W-1:0] wr_idx,
    input  logic [XLEN-1:0]      wr_data
);

    logic [XLEN-1:0] regs [REG_COUNT];

    // Write port, whole array cleared on reset
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int k = 0; k < REG_COUNT; k++) begin
                regs[k] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Read ports
    // Same-cycle write wins so the instruction two ahead is seen
    assign rs1_data = (rs1_idx == '0)                 ? '0      :
                      (wr_en && (wr_idx == rs1_idx))  ? wr_data :
                                                        regs[rs1_idx];

    assign rs2_data = (rs2_idx == '0)                 ? '0      :
                      (wr_en && (wr_idx == rs2_idx))  ? wr_data :
                                                        regs[rs2_idx];

endmodule

`default_nettype wire

/* isa_pkg.sv */
/*
 * RV32I ALU subset definitions
 * Opcodes, funct fields, ALU operation codes and the instruction
 * word with its R-type and I-type views
 */
`default_nettype none

package isa_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Opcodes and function fields
    ////////////////////////////////////////////////////////////////////////////

    // Register-register group
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    // Register-immediate group
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // funct3, same meaning in both groups
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct7, base encoding and the SUB / SRA alternate
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    ////////////////////////////////////////////////////////////////////////////
    // ALU operations
    ////////////////////////////////////////////////////////////////////////////

    localparam int ALU_OP_W = 4;

    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd9;

    // Instruction word, one view per format
    // r.funct7 overlays i.imm[11:5], so the shift-immediate check can share it
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } inst_word_t;

endpackage

`default_nettype wire

/* core_pkg.sv */
/*
 * Core-wide sizes
 * Data width, register file geometry and error status codes
 */
`default_nettype none

package core_pkg;

    // Datapath width
    localparam int XLEN = 32;

    // Architectural registers
    localparam int REG_COUNT = 32;
    localparam int REG_IDX_W = 5;

    // Error status
    localparam int ERR_W = 2;

    // Running normally
    localparam logic [ERR_W-1:0] ERR_NONE    = 2'd0;
    // Halted on an undecodable instruction
    localparam logic [ERR_W-1:0] ERR_ILLEGAL = 2'd1;

endpackage

`default_nettype wire
